// File: src/disc_cfg.svh
// Build-time sizes of the sample discriminator: channel count,
// sample width, samples per word, sample index width and timer width

`ifndef DISC_CFG_SVH
`define DISC_CFG_SVH

// number of independent acquisition channels
`define DISC_N_CHANNELS 2

// bits per sample, two's complement
`define DISC_SAMPLE_WIDTH 16

// samples carried side by side in one word
`define DISC_PARALLEL 4

// width of the per-channel count of forwarded words
`define DISC_INDEX_WIDTH 14

// width of the per-channel count of all valid words
`define DISC_TIMER_WIDTH 50

`endif

// File: src/disc_pkg.sv
// Shared packed types of the sample discriminator: sample word,
// threshold pair, configuration word, execute result and timestamp

`default_nettype none

`include "disc_cfg.svh"

package disc_pkg;

  // one channel's parallel samples, sample 0 in the lowest bits
  typedef logic [`DISC_PARALLEL-1:0][`DISC_SAMPLE_WIDTH-1:0] sample_word_t;

  // hysteresis band of one channel, high threshold in the upper half
  typedef struct packed {
    logic [`DISC_SAMPLE_WIDTH-1:0] high;
    logic [`DISC_SAMPLE_WIDTH-1:0] low;
  } thresh_t;

  // threshold pairs of all channels as they arrive on the config port,
  // channel 0 in the lowest bits
  typedef thresh_t [`DISC_N_CHANNELS-1:0] config_t;

  // word leaving the execute stage with its event decision
  typedef struct packed {
    sample_word_t data;
    logic         keep;      // channel is inside an event after this word
    logic         new_event; // this word opened the event
  } exec_t;

  // event start marker, timer above the sample index
  typedef struct packed {
    logic [`DISC_TIMER_WIDTH-1:0] timer;
    logic [`DISC_INDEX_WIDTH-1:0] index;
  } stamp_t;

endpackage

`default_nettype wire

// File: src/threshold_decode.sv
// Threshold configuration stage: latches the packed configuration
// word on its strobe and hands out one threshold pair per channel

`timescale 1ns/10ps
`default_nettype none

`include "disc_cfg.svh"

module threshold_decode
  import disc_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire config_t                      config_in,
  input  wire logic                         config_valid,
  output thresh_t [`DISC_N_CHANNELS-1:0]    thresholds
);

  // live threshold pairs, indexed by channel
  thresh_t [`DISC_N_CHANNELS-1:0] thresh_q;

  // a new configuration takes effect on the edge after its strobe, so a
  // word sampled on that edge is still compared against the old band
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
        thresh_q[ch].high <= '0;
        thresh_q[ch].low  <= '0;
      end
    end else if (config_valid) begin
      for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
        // each channel owns one 2*SAMPLE_WIDTH slice of the config word,
        // high threshold above low inside the slice
        thresh_q[ch].high <= config_in[ch].high;
        thresh_q[ch].low  <= config_in[ch].low;
      end
    end
  end

  // the execute stage only ever sees the unpacked per-channel pairs
  always_comb begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      thresholds[ch] = thresh_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: src/hysteresis_execute.sv
// Hysteresis decision stage: compares every sample of each channel
// against its threshold pair, tracks the per-channel event state and
// registers the word with its keep and new_event flags

`timescale 1ns/10ps
`default_nettype none

`include "disc_cfg.svh"

module hysteresis_execute
  import disc_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                reset_state,
  input  wire thresh_t [`DISC_N_CHANNELS-1:0]      thresholds,
  input  wire sample_word_t [`DISC_N_CHANNELS-1:0] data_in,
  input  wire logic [`DISC_N_CHANNELS-1:0]         data_valid,
  output exec_t [`DISC_N_CHANNELS-1:0]             exec,
  output logic [`DISC_N_CHANNELS-1:0]              exec_valid
);

  // per-channel comparison results for the word on data_in
  logic [`DISC_N_CHANNELS-1:0] any_high;
  logic [`DISC_N_CHANNELS-1:0] all_low;

  // event state before and after the current word
  logic [`DISC_N_CHANNELS-1:0] in_event;
  logic [`DISC_N_CHANNELS-1:0] next_event;

  // samples and thresholds are two's complement values
  always_comb begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      any_high[ch] = 1'b0;
      all_low[ch]  = 1'b1;
      for (int s = 0; s < `DISC_PARALLEL; s++) begin
        if ($signed(data_in[ch][s]) > $signed(thresholds[ch].high)) begin
          any_high[ch] = 1'b1;
        end
        if (!($signed(data_in[ch][s]) < $signed(thresholds[ch].low))) begin
          all_low[ch] = 1'b0;
        end
      end
    end
  end

  // a sample above the high threshold wins over the low test, so an
  // inverted band still opens events
  always_comb begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      if (any_high[ch]) begin
        next_event[ch] = 1'b1;
      end else if (all_low[ch]) begin
        next_event[ch] = 1'b0;
      end else begin
        next_event[ch] = in_event[ch];
      end
    end
  end

  // the state only moves on valid words
  always_ff @(posedge clk) begin
    if (reset || reset_state) begin
      in_event <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
        if (data_valid[ch]) begin
          in_event[ch] <= next_event[ch];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exec_valid <= '0;
    end else begin
      exec_valid <= data_valid;
    end
  end

  // word and flags ride together into the result stage
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      exec[ch].data      <= data_in[ch];
      exec[ch].keep      <= next_event[ch];
      exec[ch].new_event <= next_event[ch] & ~in_event[ch];
    end
  end

endmodule

`default_nettype wire

// File: src/timestamp_result.sv
// Result stage: per-channel word timer and forwarded-word index,
// registered data outputs for kept words and a timestamp per event start

`timescale 1ns/10ps
`default_nettype none

`include "disc_cfg.svh"

module timestamp_result
  import disc_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                reset_state,
  input  wire exec_t [`DISC_N_CHANNELS-1:0]        exec,
  input  wire logic [`DISC_N_CHANNELS-1:0]         exec_valid,
  output sample_word_t [`DISC_N_CHANNELS-1:0]      data_out,
  output logic [`DISC_N_CHANNELS-1:0]              data_out_valid,
  output stamp_t [`DISC_N_CHANNELS-1:0]            stamp_out,
  output logic [`DISC_N_CHANNELS-1:0]              stamp_valid
);

  // free-running count of every valid word seen by a channel
  logic [`DISC_N_CHANNELS-1:0][`DISC_TIMER_WIDTH-1:0] timer;

  // count of forwarded words since reset or the last reset_state
  logic [`DISC_N_CHANNELS-1:0][`DISC_INDEX_WIDTH-1:0] index;

  // kept and event-start qualifiers for this cycle's words
  logic [`DISC_N_CHANNELS-1:0] kept;
  logic [`DISC_N_CHANNELS-1:0] started;

  always_comb begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      kept[ch]    = exec_valid[ch] & exec[ch].keep;
      started[ch] = exec_valid[ch] & exec[ch].new_event;
    end
  end

  // reset_state leaves the timer alone so event times stay continuous
  always_ff @(posedge clk) begin
    if (reset) begin
      timer <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
        if (exec_valid[ch]) begin
          timer[ch] <= timer[ch] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || reset_state) begin
      index <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
        if (kept[ch]) begin
          index[ch] <= index[ch] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out_valid <= '0;
      stamp_valid    <= '0;
    end else begin
      data_out_valid <= kept;
      stamp_valid    <= started;
    end
  end

  // the stamp holds the counts from before the opening word, so the first
  // word of an event carries the index of its own position in the stream
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < `DISC_N_CHANNELS; ch++) begin
      data_out[ch] <= exec[ch].data;
      if (started[ch]) begin
        stamp_out[ch].timer <= timer[ch];
        stamp_out[ch].index <= index[ch];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/sample_discriminator.sv
// Multi-channel sample discriminator top level: threshold decode,
// hysteresis execute and timestamp result stages in a two-cycle pipeline

`timescale 1ns/10ps
`default_nettype none

`include "disc_cfg.svh"

module sample_discriminator
  import disc_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                reset,
  // clears event state and sample index, but not the timers
  input  wire logic                                reset_state,

  // threshold pairs of all channels, one-cycle strobe
  input  wire config_t                             config_in,
  input  wire logic                                config_valid,

  // incoming words, one strobe per channel and no back-pressure
  input  wire sample_word_t [`DISC_N_CHANNELS-1:0] data_in,
  input  wire logic [`DISC_N_CHANNELS-1:0]         data_valid,

  // forwarded words, two cycles after their input strobe
  output sample_word_t [`DISC_N_CHANNELS-1:0]      data_out,
  output logic [`DISC_N_CHANNELS-1:0]              data_out_valid,

  // event start markers, aligned with the opening word on data_out
  output stamp_t [`DISC_N_CHANNELS-1:0]            stamp_out,
  output logic [`DISC_N_CHANNELS-1:0]              stamp_valid
);

  thresh_t [`DISC_N_CHANNELS-1:0] thresholds;
  exec_t [`DISC_N_CHANNELS-1:0]   exec;
  logic [`DISC_N_CHANNELS-1:0]    exec_valid;

  threshold_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .config_in    (config_in),
    .config_valid (config_valid),
    .thresholds   (thresholds)
  );

  hysteresis_execute u_execute (
    .clk         (clk),
    .reset       (reset),
    .reset_state (reset_state),
    .thresholds  (thresholds),
    .data_in     (data_in),
    .data_valid  (data_valid),
    .exec        (exec),
    .exec_valid  (exec_valid)
  );

  timestamp_result u_result (
    .clk            (clk),
    .reset          (reset),
    .reset_state    (reset_state),
    .exec           (exec),
    .exec_valid     (exec_valid),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .stamp_out      (stamp_out),
    .stamp_valid    (stamp_valid)
  );

endmodule

`default_nettype wire

// File: tests/tb_sample_discriminator.sv
// Testbench for the sample discriminator with clock and reset, random sample
// stimulus, a hysteresis reference model with expected queues, checking
// assertions on every output strobe, a watchdog and the summary line

`timescale 1ns/10ps
`default_nettype none

`include "disc_cfg.svh"

module tb_sample_discriminator
  import disc_pkg::*;
;

  localparam int NCH        = `DISC_N_CHANNELS;
  localparam int SW         = `DISC_SAMPLE_WIDTH;
  localparam int CLK_PERIOD = 10;
  localparam int N_PH1      = 20;
  localparam int N_PH2      = 15;
  localparam int N_PH3      = 200;
  localparam int N_PH4      = 150;
  localparam int N_PH5      = 40;
  // the two extra words are the forced event openers around reset_state
  localparam int TOTAL_WORDS = N_PH1 + N_PH2 + N_PH3 + N_PH4 + N_PH5 + 2;

  logic                      clk;
  logic                      reset;
  logic                      reset_state;
  config_t                   config_in;
  logic                      config_valid;
  sample_word_t [NCH-1:0]    data_in;
  logic [NCH-1:0]            data_valid;
  sample_word_t [NCH-1:0]    data_out;
  logic [NCH-1:0]            data_out_valid;
  stamp_t [NCH-1:0]          stamp_out;
  logic [NCH-1:0]            stamp_valid;

  // expected outputs per channel that the model fills at drive time
  sample_word_t exp_data [NCH][$];
  stamp_t       exp_stamp [NCH][$];

  // for every expected word whether it opens an event and the edge it is due on
  logic         exp_open [NCH][$];
  int           exp_due [NCH][$];

  // model state that mirrors what the channel has seen so far
  thresh_t                      model_thr [NCH];
  logic                         model_ev [NCH];
  logic [`DISC_TIMER_WIDTH-1:0] model_timer [NCH];
  logic [`DISC_INDEX_WIDTH-1:0] model_index [NCH];

  int seed;
  int errors;
  int edge_count;
  int sent_words [NCH];
  int data_seen [NCH];
  int stamps_seen [NCH];

  sample_discriminator u_dut (
    .clk            (clk),
    .reset          (reset),
    .reset_state    (reset_state),
    .config_in      (config_in),
    .config_valid   (config_valid),
    .data_in        (data_in),
    .data_valid     (data_valid),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .stamp_out      (stamp_out),
    .stamp_valid    (stamp_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // rising edges seen so far, used to check the two-cycle latency
  always @(posedge clk) begin
    edge_count++;
  end

  function automatic logic chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // every sample of the word drawn from [lo, hi]
  function automatic sample_word_t random_word(input int lo, input int hi);
    sample_word_t w;
    int r;
    for (int s = 0; s < `DISC_PARALLEL; s++) begin
      r = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
      w[s] = r[SW-1:0];
    end
    return w;
  endfunction

  function automatic sample_word_t const_word(input int v);
    sample_word_t w;
    for (int s = 0; s < `DISC_PARALLEL; s++) begin
      w[s] = v[SW-1:0];
    end
    return w;
  endfunction

  function automatic config_t make_config(input int h0, input int l0, input int h1, input int l1);
    config_t c;
    c[0].high = h0[SW-1:0];
    c[0].low  = l0[SW-1:0];
    c[1].high = h1[SW-1:0];
    c[1].low  = l1[SW-1:0];
    return c;
  endfunction

  // any sample above high opens or holds an event, all samples below low
  // close it and anything else keeps the state
  task automatic model_word(input int ch, input sample_word_t w);
    int n_above;
    int n_below;
    logic next_ev;
    stamp_t st;
    n_above = 0;
    n_below = 0;
    for (int s = 0; s < `DISC_PARALLEL; s++) begin
      if ($signed(w[s]) > $signed(model_thr[ch].high)) n_above++;
      if ($signed(w[s]) < $signed(model_thr[ch].low)) n_below++;
    end
    if (n_above > 0) next_ev = 1'b1;
    else if (n_below == `DISC_PARALLEL) next_ev = 1'b0;
    else next_ev = model_ev[ch];
    if (next_ev) begin
      exp_data[ch].push_back(w);
      exp_open[ch].push_back(!model_ev[ch]);
      exp_due[ch].push_back(edge_count + 2);
      if (!model_ev[ch]) begin
        st.timer = model_timer[ch];
        st.index = model_index[ch];
        exp_stamp[ch].push_back(st);
      end
      model_index[ch] = model_index[ch] + 1'b1;
    end
    model_timer[ch] = model_timer[ch] + 1'b1;
    model_ev[ch] = next_ev;
  endtask

  // words in this cycle still see the old thresholds
  task automatic drive_cycle(input logic [NCH-1:0] valid, input sample_word_t [NCH-1:0] words,
                             input logic cfg_strobe, input config_t cfg);
    @(posedge clk);
    #1;
    data_valid   = valid;
    data_in      = words;
    config_valid = cfg_strobe;
    config_in    = cfg;
    for (int ch = 0; ch < NCH; ch++) begin
      if (valid[ch]) begin
        model_word(ch, words[ch]);
        sent_words[ch]++;
      end
    end
    if (cfg_strobe) begin
      for (int ch = 0; ch < NCH; ch++) model_thr[ch] = cfg[ch];
    end
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) drive_cycle('0, '0, 1'b0, '0);
  endtask

  task automatic stream(input int n, input int lo0, input int hi0, input int lo1, input int hi1,
                        input int pct, input logic cfg_strobe, input config_t cfg);
    logic [NCH-1:0] valid;
    sample_word_t [NCH-1:0] words;
    for (int i = 0; i < n; i++) begin
      for (int ch = 0; ch < NCH; ch++) begin
        valid[ch] = chance(pct);
        words[ch] = (ch == 0) ? random_word(lo0, hi0) : random_word(lo1, hi1);
      end
      drive_cycle(valid, words, cfg_strobe && (i == 0), cfg);
    end
  endtask

  task automatic pulse_reset_state();
    @(posedge clk);
    #1;
    data_valid   = '0;
    config_valid = 1'b0;
    reset_state  = 1'b1;
    for (int ch = 0; ch < NCH; ch++) begin
      model_ev[ch]    = 1'b0;
      model_index[ch] = '0;
    end
    @(posedge clk);
    #1;
    reset_state = 1'b0;
  endtask

  // outputs are settled half a cycle after the edge that updates them
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      for (int ch = 0; ch < NCH; ch++) begin
        if (data_out_valid[ch] === 1'b1) begin
          assert (exp_data[ch].size() > 0) else begin
            $display("ERR %0t: channel %0d forwarded a word the model dropped", $time, ch);
            errors++;
          end
          if (exp_data[ch].size() > 0) begin
            assert (data_out[ch] === exp_data[ch][0]) else begin
              $display("ERR %0t: channel %0d data %h, expected %h",
                       $time, ch, data_out[ch], exp_data[ch][0]);
              errors++;
            end
            assert (edge_count == exp_due[ch][0]) else begin
              $display("ERR %0t: channel %0d word arrived at edge %0d, expected edge %0d",
                       $time, ch, edge_count, exp_due[ch][0]);
              errors++;
            end
            assert (stamp_valid[ch] === exp_open[ch][0]) else begin
              $display("ERR %0t: channel %0d stamp_valid %b beside this word, expected %b",
                       $time, ch, stamp_valid[ch], exp_open[ch][0]);
              errors++;
            end
            void'(exp_data[ch].pop_front());
            void'(exp_open[ch].pop_front());
            void'(exp_due[ch].pop_front());
          end
          data_seen[ch]++;
        end
        if (stamp_valid[ch] === 1'b1) begin
          assert (exp_stamp[ch].size() > 0) else begin
            $display("ERR %0t: channel %0d emitted a stamp with no event start", $time, ch);
            errors++;
          end
          if (exp_stamp[ch].size() > 0) begin
            assert (stamp_out[ch] === exp_stamp[ch][0]) else begin
              $display("ERR %0t: channel %0d stamp timer %0d index %0d, expected %0d / %0d",
                       $time, ch, stamp_out[ch].timer, stamp_out[ch].index,
                       exp_stamp[ch][0].timer, exp_stamp[ch][0].index);
              errors++;
            end
            void'(exp_stamp[ch].pop_front());
          end
          stamps_seen[ch]++;
        end
      end
    end
  end

  initial begin
    #((TOTAL_WORDS + 200) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    int data_before [NCH];
    int stamps_before [NCH];
    int total_data;
    int total_stamps;
    seed         = 32'hd962;
    errors       = 0;
    edge_count   = 0;
    clk          = 1'b0;
    reset        = 1'b1;
    reset_state  = 1'b0;
    config_in    = '0;
    config_valid = 1'b0;
    data_in      = '0;
    data_valid   = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      model_thr[ch]   = '0;
      model_ev[ch]    = 1'b0;
      model_timer[ch] = '0;
      model_index[ch] = '0;
      sent_words[ch]  = 0;
      data_seen[ch]   = 0;
      stamps_seen[ch] = 0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // zero thresholds with positive samples keep every word
    stream(N_PH1, 1, 1000, 100, 3000, 100, 1'b0, '0);
    idle(6);
    for (int ch = 0; ch < NCH; ch++) begin
      assert (data_seen[ch] == sent_words[ch] && stamps_seen[ch] == 1) else begin
        $display("ERR %0t: channel %0d passed %0d of %0d words with %0d stamps",
                 $time, ch, data_seen[ch], sent_words[ch], stamps_seen[ch]);
        errors++;
      end
      data_before[ch]   = data_seen[ch];
      stamps_before[ch] = stamps_seen[ch];
    end

    // everything below the band closes the event and stays silent
    drive_cycle('0, '0, 1'b1, make_config(1000, 500, 1000, 500));
    stream(N_PH2, -2000, 400, -2000, 400, 75, 1'b0, '0);
    idle(6);
    for (int ch = 0; ch < NCH; ch++) begin
      assert (data_seen[ch] == data_before[ch] && stamps_seen[ch] == stamps_before[ch]) else begin
        $display("ERR %0t: channel %0d produced output below both thresholds", $time, ch);
        errors++;
      end
    end

    // narrow bands that the samples straddle
    drive_cycle('0, '0, 1'b1, make_config(100, 50, -20, -40));
    stream(N_PH3, -200, 110, -300, -10, 75, 1'b0, '0);

    // channel 0 retuned while both channels keep streaming
    stream(N_PH4, -200, 110, -300, -10, 75, 1'b1, make_config(30, -30, -20, -40));

    // both channels sit inside an event when reset_state arrives
    drive_cycle('1, {const_word(-5), const_word(100)}, 1'b0, '0);
    idle(4);
    pulse_reset_state();
    idle(2);
    drive_cycle('1, {const_word(-5), const_word(100)}, 1'b0, '0);
    stream(N_PH5, -200, 110, -300, -10, 75, 1'b0, '0);
    idle(6);

    total_data   = 0;
    total_stamps = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      if (exp_data[ch].size() != 0 || exp_stamp[ch].size() != 0) begin
        $display("channel %0d finished with %0d words and %0d stamps never delivered",
                 ch, exp_data[ch].size(), exp_stamp[ch].size());
        errors++;
      end
      total_data   += data_seen[ch];
      total_stamps += stamps_seen[ch];
    end

    $display("errors: %0d, words checked: %0d, stamps checked: %0d",
             errors, total_data, total_stamps);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/disc_pkg.sv
src/threshold_decode.sv
src/hysteresis_execute.sv
src/timestamp_result.sv
src/sample_discriminator.sv
tests/tb_sample_discriminator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sample discriminator testbench with Verilator, runs it and
# decides pass or fail by searching the simulation log for the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module tb_sample_discriminator \
  && ./obj_dir/Vtb_sample_discriminator | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -qx "Everything OK" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
